//--- rtl/correlator_bank.sv
`timescale 1ns/1ps

module correlator_bank #(
   parameter int VIS_COUNT = vis_pkg::DEF_VIS_COUNT,
   parameter int ADDR_BITS = vis_pkg::DEF_ADDR_BITS
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // incoming samples
   input  logic                             sample_valid_i,
   input  logic [ADDR_BITS-1:0]             sample_idx_i,
   input  logic [vis_pkg::SAMPLE_WIDTH-1:0] sample_dat_i,
   // bank control
   input  logic                             swap_i,       // one-cycle pulse
   output logic                             switching_o,  // swap_i delayed by one
   // slave read bus, always sees the frozen bank
   input  logic                             cyc_i,
   input  logic                             stb_i,
   input  logic [ADDR_BITS-1:0]             adr_i,
   output logic                             ack_o,
   output logic [vis_pkg::VIS_WIDTH-1:0]    dat_o
);

   localparam logic [ADDR_BITS-1:0] LAST_IDX = ADDR_BITS'(VIS_COUNT - 1);

   logic [vis_pkg::VIS_WIDTH-1:0] bank_q [2][VIS_COUNT]; // two accumulator banks
   logic                          act_sel_q;             // bank taking samples
   logic                          frz_sel;               // bank read out
   logic                          clearing_q;            // wiping the new active bank
   logic [ADDR_BITS-1:0]          clr_cnt_q;
   logic                          acc_en;
   logic [vis_pkg::VIS_WIDTH-1:0] sample_ext;

   assign frz_sel    = ~act_sel_q;
   assign sample_ext = {{(vis_pkg::VIS_WIDTH - vis_pkg::SAMPLE_WIDTH){1'b0}}, sample_dat_i};
   assign acc_en     = sample_valid_i & ~swap_i & ~clearing_q; // samples dropped otherwise

   // --------------------------------------------------
   // bank select and clear sequencing
   // --------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         act_sel_q   <= 1'b0;
         clearing_q  <= 1'b0;
         clr_cnt_q   <= '0;
         switching_o <= 1'b0;
      end else begin
         switching_o <= swap_i;
         if (swap_i) begin
            act_sel_q  <= ~act_sel_q;  // old bank freezes here
            clearing_q <= 1'b1;
            clr_cnt_q  <= '0;
         end else if (clearing_q) begin
            clr_cnt_q <= clr_cnt_q + ADDR_BITS'(1);
            if (clr_cnt_q == LAST_IDX) begin
               clearing_q <= 1'b0;       // last entry wiped this cycle
            end
         end
      end
   end

   // --------------------------------------------------
   // accumulators
   // --------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < VIS_COUNT; i++) begin
            bank_q[0][i] <= '0;
            bank_q[1][i] <= '0;
         end
      end else if (clearing_q && !swap_i) begin
         bank_q[act_sel_q][clr_cnt_q] <= '0;  // one word per cycle
      end else if (acc_en) begin
         bank_q[act_sel_q][sample_idx_i] <= bank_q[act_sel_q][sample_idx_i] + sample_ext;
      end
   end

   // read port, single cycle ack
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack_o <= 1'b0;
      end else begin
         ack_o <= cyc_i & stb_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (cyc_i && stb_i) begin
         dat_o <= bank_q[frz_sel][adr_i];
      end
   end

endmodule

//--- rtl/vis_pkg.sv
// shared widths, defaults and the buffer word type for the visibility readout path

package vis_pkg;

   // --------------------------------------------------
   // datapath widths
   // --------------------------------------------------
   localparam int VIS_WIDTH    = 32;  // one visibility accumulator
   localparam int SAMPLE_WIDTH = 8;   // one incoming correlator sample

   // --------------------------------------------------
   // default sizes, overridden from vis_top
   // --------------------------------------------------
   localparam int DEF_VIS_COUNT = 16; // words per bank
   localparam int DEF_ADDR_BITS = 4;  // word address width

   // --------------------------------------------------
   // buffer word
   // --------------------------------------------------
   // the prefetcher writes and sums whole words
   // the host side picks single bytes out of the same word
   // byte 0 is the least significant one, so the host sees little-endian order
   typedef union packed {
      logic [VIS_WIDTH-1:0] word;   // whole visibility
      logic [3:0][7:0]      bytes;  // bytes[0] = word[7:0]
   } vis_word_u;

endpackage

//--- rtl/vis_prefetch.sv
`timescale 1ns/1ps

module vis_prefetch #(
   parameter int VIS_COUNT = vis_pkg::DEF_VIS_COUNT,
   parameter int ADDR_BITS = vis_pkg::DEF_ADDR_BITS
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   input  logic                          begin_i,     // bank switch seen
   output logic                          ready_o,     // whole frame buffered
   output logic [vis_pkg::VIS_WIDTH-1:0] checksum_o,
   // master side, towards the correlator bank
   output logic                          a_cyc_o,
   output logic                          a_stb_o,
   output logic [ADDR_BITS-1:0]          a_adr_o,
   input  logic                          a_ack_i,
   input  logic [vis_pkg::VIS_WIDTH-1:0] a_dat_i,
   // buffer side, write only
   output logic                          b_stb_o,
   output logic [ADDR_BITS-1:0]          b_adr_o,
   output logic [vis_pkg::VIS_WIDTH-1:0] b_dat_o,
   input  logic                          b_ack_i
);

   localparam logic [1:0] ST_IDLE  = 2'd0;
   localparam logic [1:0] ST_FETCH = 2'd1;  // waiting on the correlator ack
   localparam logic [1:0] ST_STORE = 2'd2;  // waiting on the buffer ack

   localparam logic [ADDR_BITS-1:0] LAST_IDX = ADDR_BITS'(VIS_COUNT - 1);

   logic [1:0]           state_q;
   logic [ADDR_BITS-1:0] cnt_q;      // word being moved
   vis_pkg::vis_word_u   word_q;     // fetched word, held for the buffer write
   logic                 last_word;

   // same index on both sides, words land in order
   assign a_adr_o   = cnt_q;
   assign b_adr_o   = cnt_q;
   assign b_dat_o   = word_q.word;
   assign last_word = (cnt_q == LAST_IDX);

   // --------------------------------------------------
   // transfer FSM
   // --------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q    <= ST_IDLE;
         cnt_q      <= '0;
         ready_o    <= 1'b0;
         checksum_o <= '0;
         a_cyc_o    <= 1'b0;
         a_stb_o    <= 1'b0;
         b_stb_o    <= 1'b0;
      end else if (begin_i) begin
         // new frame, also restarts a running copy
         state_q    <= ST_FETCH;
         cnt_q      <= '0;
         ready_o    <= 1'b0;
         checksum_o <= '0;
         a_cyc_o    <= 1'b1;
         a_stb_o    <= 1'b1;
         b_stb_o    <= 1'b0;
      end else begin
         case (state_q)
            ST_FETCH: begin
               a_stb_o <= 1'b0;               // strobe is a single pulse
               if (a_ack_i) begin
                  b_stb_o <= 1'b1;
                  state_q <= ST_STORE;
               end
            end
            ST_STORE: begin
               b_stb_o <= 1'b0;
               if (b_ack_i) begin
                  checksum_o <= checksum_o + word_q.word; // wraps at 32 bits
                  if (last_word) begin
                     ready_o <= 1'b1;         // held until next begin_i
                     a_cyc_o <= 1'b0;
                     state_q <= ST_IDLE;
                  end else begin
                     cnt_q   <= cnt_q + ADDR_BITS'(1);
                     a_stb_o <= 1'b1;         // next request
                     state_q <= ST_FETCH;
                  end
               end
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // capture register
   always_ff @(posedge clk_i) begin
      if (state_q == ST_FETCH && a_ack_i) begin
         word_q <= a_dat_i;
      end
   end

endmodule

//--- rtl/vis_readout.sv
`timescale 1ns/1ps

module vis_readout #(
   parameter int VIS_COUNT = vis_pkg::DEF_VIS_COUNT,
   parameter int ADDR_BITS = vis_pkg::DEF_ADDR_BITS
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   // status
   input  logic                          switching_i,
   output logic                          available_o,
   output logic [vis_pkg::VIS_WIDTH-1:0] checksum_o,
   // master bus to the correlator bank
   output logic                          cor_cyc_o,
   output logic                          cor_stb_o,
   output logic [ADDR_BITS-1:0]          cor_adr_o,
   input  logic                          cor_ack_i,
   input  logic [vis_pkg::VIS_WIDTH-1:0] cor_dat_i,
   // host byte bus, read only
   input  logic                          cyc_i,
   input  logic                          stb_i,
   input  logic [ADDR_BITS+1:0]          adr_i,
   output logic                          ack_o,
   output logic [7:0]                    byt_o
);

   // prefetcher to buffer
   logic                          buf_stb;
   logic [ADDR_BITS-1:0]          buf_adr;
   logic [vis_pkg::VIS_WIDTH-1:0] buf_dat;
   logic                          buf_ack;

   // copies the frozen bank after every switch
   vis_prefetch #(
      .VIS_COUNT (VIS_COUNT),
      .ADDR_BITS (ADDR_BITS)
   ) u_prefetch (
      .clk_i      (clk_i),
      .rst_n_i    (rst_n_i),
      .begin_i    (switching_i),
      .ready_o    (available_o),
      .checksum_o (checksum_o),
      .a_cyc_o    (cor_cyc_o),
      .a_stb_o    (cor_stb_o),
      .a_adr_o    (cor_adr_o),
      .a_ack_i    (cor_ack_i),
      .a_dat_i    (cor_dat_i),
      .b_stb_o    (buf_stb),
      .b_adr_o    (buf_adr),
      .b_dat_o    (buf_dat),
      .b_ack_i    (buf_ack)
   );

   // frame buffer, host reads one byte at a time
   vis_sram #(
      .VIS_COUNT (VIS_COUNT),
      .ADDR_BITS (ADDR_BITS)
   ) u_sram (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .a_stb_i (buf_stb),
      .a_adr_i (buf_adr),
      .a_dat_i (buf_dat),
      .a_ack_o (buf_ack),
      .b_cyc_i (cyc_i),
      .b_stb_i (stb_i),
      .b_adr_i (adr_i),
      .b_ack_o (ack_o),
      .b_byt_o (byt_o)
   );

endmodule

//--- rtl/vis_sram.sv
`timescale 1ns/1ps

module vis_sram #(
   parameter int VIS_COUNT = vis_pkg::DEF_VIS_COUNT,
   parameter int ADDR_BITS = vis_pkg::DEF_ADDR_BITS
) (
   input  logic                          clk_i,
   input  logic                          rst_n_i,
   // port A, word writes from the prefetcher
   input  logic                          a_stb_i,
   input  logic [ADDR_BITS-1:0]          a_adr_i,
   input  logic [vis_pkg::VIS_WIDTH-1:0] a_dat_i,
   output logic                          a_ack_o,
   // port B, host byte reads
   input  logic                          b_cyc_i,
   input  logic                          b_stb_i,
   input  logic [ADDR_BITS+1:0]          b_adr_i,  // byte address
   output logic                          b_ack_o,
   output logic [7:0]                    b_byt_o
);

   vis_pkg::vis_word_u   mem_q [VIS_COUNT];
   logic [ADDR_BITS-1:0] b_word;   // word select
   logic [1:0]           b_lane;   // byte within word
   logic                 b_req;

   assign b_word = b_adr_i[ADDR_BITS+1:2];
   assign b_lane = b_adr_i[1:0];
   assign b_req  = b_cyc_i & b_stb_i;

   // --------------------------------------------------
   // storage and read data
   // --------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (a_stb_i) begin
         mem_q[a_adr_i].word <= a_dat_i;
      end
      if (b_req) begin
         b_byt_o <= mem_q[b_word].bytes[b_lane];  // old data on a same-cycle write
      end
   end

   // handshakes
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         a_ack_o <= 1'b0;
         b_ack_o <= 1'b0;
      end else begin
         a_ack_o <= a_stb_i;  // write done at the same edge
         b_ack_o <= b_req;
      end
   end

endmodule

//--- rtl/vis_top.sv
`timescale 1ns/1ps

module vis_top #(
   parameter int VIS_COUNT = vis_pkg::DEF_VIS_COUNT,
   parameter int ADDR_BITS = vis_pkg::DEF_ADDR_BITS
) (
   input  logic                             clk_i,
   input  logic                             rst_n_i,
   // sample port
   input  logic                             sample_valid_i,
   input  logic [ADDR_BITS-1:0]             sample_idx_i,
   input  logic [vis_pkg::SAMPLE_WIDTH-1:0] sample_dat_i,
   input  logic                             swap_i,
   // frame status
   output logic                             available_o,
   output logic [vis_pkg::VIS_WIDTH-1:0]    checksum_o,
   // host port
   input  logic                             cyc_i,
   input  logic                             stb_i,
   input  logic [ADDR_BITS+1:0]             adr_i,
   output logic                             ack_o,
   output logic [7:0]                       byt_o
);

   logic                          switching;
   logic                          cor_cyc, cor_stb, cor_ack;
   logic [ADDR_BITS-1:0]          cor_adr;
   logic [vis_pkg::VIS_WIDTH-1:0] cor_dat;

   correlator_bank #(.VIS_COUNT(VIS_COUNT), .ADDR_BITS(ADDR_BITS)) u_corr (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .sample_valid_i (sample_valid_i), .sample_idx_i (sample_idx_i),
      .sample_dat_i (sample_dat_i), .swap_i (swap_i), .switching_o (switching),
      .cyc_i (cor_cyc), .stb_i (cor_stb), .adr_i (cor_adr),
      .ack_o (cor_ack), .dat_o (cor_dat)
   );

   vis_readout #(.VIS_COUNT(VIS_COUNT), .ADDR_BITS(ADDR_BITS)) u_readout (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .switching_i (switching), .available_o (available_o), .checksum_o (checksum_o),
      .cor_cyc_o (cor_cyc), .cor_stb_o (cor_stb), .cor_adr_o (cor_adr),
      .cor_ack_i (cor_ack), .cor_dat_i (cor_dat),
      .cyc_i (cyc_i), .stb_i (stb_i), .adr_i (adr_i), .ack_o (ack_o), .byt_o (byt_o)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the visibility readout testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module vis_tb -f vis_top.f -o vis_sim
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/vis_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TB PASSED" sim.log; then
   exit 0
else
   echo "pass message not found in sim.log"
   exit 1
fi

//--- include/vis_model.svh
`ifndef VIS_MODEL_SVH
`define VIS_MODEL_SVH

// reference model, included inside the testbench module
// call step_model once per clock with the inputs driven for that cycle

localparam int MDL_VIS_COUNT = vis_pkg::DEF_VIS_COUNT;

logic [vis_pkg::VIS_WIDTH-1:0] mdl_bank [2][MDL_VIS_COUNT]; // both banks
logic                          mdl_sel;                     // active bank
int                            mdl_clear_left;              // cycles of dropped samples
vis_pkg::vis_word_u            mdl_frame [MDL_VIS_COUNT];   // buffer image

// --------------------------------------------------
// state updates
// --------------------------------------------------
function automatic void reset_model();
   for (int i = 0; i < MDL_VIS_COUNT; i++) begin
      mdl_bank[0][i]      = '0;
      mdl_bank[1][i]      = '0;
      mdl_frame[i].word   = '0;
   end
   mdl_sel        = 1'b0;
   mdl_clear_left = 0;
endfunction

function automatic void step_model(input logic                             valid,
                                   input logic [vis_pkg::DEF_ADDR_BITS-1:0] idx,
                                   input logic [vis_pkg::SAMPLE_WIDTH-1:0]  dat,
                                   input logic                             swap);
   if (swap) begin
      for (int i = 0; i < MDL_VIS_COUNT; i++) begin
         mdl_frame[i].word    = mdl_bank[mdl_sel][i]; // frozen frame
         mdl_bank[!mdl_sel][i] = '0;                 // new active starts empty
      end
      mdl_sel        = !mdl_sel;
      mdl_clear_left = MDL_VIS_COUNT;                 // samples lost meanwhile
   end else if (mdl_clear_left > 0) begin
      mdl_clear_left--;
   end else if (valid) begin
      mdl_bank[mdl_sel][idx] += {{(vis_pkg::VIS_WIDTH - vis_pkg::SAMPLE_WIDTH){1'b0}}, dat};
   end
endfunction

// --------------------------------------------------
// expected values
// --------------------------------------------------
function automatic logic [7:0] expected_byte(input int byte_adr);
   return mdl_frame[byte_adr / 4].word[(byte_adr % 4) * 8 +: 8];  // little-endian, byte 0 is bits 7:0
endfunction

function automatic logic [vis_pkg::VIS_WIDTH-1:0] frame_checksum();
   logic [vis_pkg::VIS_WIDTH-1:0] sum;
   sum = '0;
   for (int i = 0; i < MDL_VIS_COUNT; i++) begin
      sum += mdl_frame[i].word;  // wraps like the hardware
   end
   return sum;
endfunction

`endif

//--- verification/vis_tb.sv
`timescale 1ns/1ps

module vis_tb;

   localparam int VIS_COUNT   = 16;
   localparam int ADDR_BITS   = 4;
   localparam int BYTES       = VIS_COUNT * 4;
   localparam int FRAMES      = 12;           // all swaps of the run
   localparam int MAX_SAMPLES = 400;          // longest fill before a swap
   localparam int TIMEOUT_CYC = FRAMES * (MAX_SAMPLES + VIS_COUNT * 8 + BYTES * 3) + 2000;

   logic                             clk_i = 1'b0;
   logic                             rst_n_i;
   logic                             sample_valid_i;
   logic [ADDR_BITS-1:0]             sample_idx_i;
   logic [vis_pkg::SAMPLE_WIDTH-1:0] sample_dat_i;
   logic                             swap_i;
   logic                             available_o;
   logic [vis_pkg::VIS_WIDTH-1:0]    checksum_o;
   logic                             cyc_i, stb_i, ack_o;
   logic [ADDR_BITS+1:0]             adr_i;
   logic [7:0]                       byt_o;

   int samp_mode = 0;   // 0 idle, 1 any index, 2 indices 0..3 only
   int cycle_cnt = 0;
   int test_errs, err_total, tests_run, tests_failed;

   `include "vis_model.svh"

   vis_top #(.VIS_COUNT(VIS_COUNT), .ADDR_BITS(ADDR_BITS)) u_dut (
      .clk_i (clk_i), .rst_n_i (rst_n_i),
      .sample_valid_i (sample_valid_i), .sample_idx_i (sample_idx_i),
      .sample_dat_i (sample_dat_i), .swap_i (swap_i),
      .available_o (available_o), .checksum_o (checksum_o),
      .cyc_i (cyc_i), .stb_i (stb_i), .adr_i (adr_i), .ack_o (ack_o), .byt_o (byt_o)
   );

   always #2 clk_i = ~clk_i;  // 4 ns period

   // run limit
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYC) begin
         $display("timeout after %0d cycles, the DUT never finished a frame or a read", cycle_cnt);
         $display("TB FAILED");
         $finish;
      end
   end

   // --------------------------------------------------
   // stimulus helpers
   // --------------------------------------------------
   // one clock: pick samples, update the model, move to 1 ns after the next edge
   task automatic step_cycle();
      sample_valid_i = (samp_mode != 0) ? 1'($urandom_range(0, 1)) : 1'b0;
      sample_idx_i   = (samp_mode == 2) ? ADDR_BITS'($urandom_range(0, 3)) : ADDR_BITS'($urandom);
      sample_dat_i   = 8'($urandom);
      step_model(sample_valid_i, sample_idx_i, sample_dat_i, swap_i);
      @(posedge clk_i);
      #1;
      swap_i = 1'b0;   // swap is a single pulse
   endtask

   task automatic read_byte(input int adr, output logic [7:0] byt);
      cyc_i = 1'b1;
      stb_i = 1'b1;
      adr_i = (ADDR_BITS + 2)'(adr);
      step_cycle();
      while (!ack_o) step_cycle();
      byt   = byt_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      step_cycle();    // stb low for a cycle between reads
   endtask

   // samples, then swap, then wait for the new frame in the buffer
   task automatic fill_and_swap(input int fill_mode, input int n, input int busy_mode);
      samp_mode = fill_mode;
      repeat (n) step_cycle();
      swap_i    = 1'b1;
      samp_mode = busy_mode;
      step_cycle();
      while (available_o) step_cycle();   // old frame flag drops first
      while (!available_o) step_cycle();
   endtask

   // --------------------------------------------------
   // checks
   // --------------------------------------------------
   task automatic check_bytes(input string name);
      logic [7:0] got;
      logic [7:0] exp;
      for (int b = 0; b < BYTES; b++) begin
         read_byte(b, got);
         exp = expected_byte(b);
         assert (got == exp) else begin
            $display("Fail %s: byte %0d expected 0x%02h actual 0x%02h", name, b, exp, got);
            test_errs++;
         end
      end
   endtask

   task automatic check_checksum(input string name);
      logic [vis_pkg::VIS_WIDTH-1:0] exp;
      exp = frame_checksum();
      assert (checksum_o == exp) else begin
         $display("Fail %s: checksum expected 0x%08h actual 0x%08h", name, exp, checksum_o);
         test_errs++;
      end
   endtask

   task automatic start_test();
      test_errs = 0;
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      err_total += test_errs;
      if (test_errs != 0) tests_failed++;
      $display("test %s done, %0d errors", name, test_errs);
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      void'($urandom(44675));
      rst_n_i = 1'b0;
      sample_valid_i = 1'b0;
      sample_idx_i = '0;
      sample_dat_i = '0;
      swap_i = 1'b0;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      adr_i = '0;
      err_total = 0;
      tests_run = 0;
      tests_failed = 0;
      reset_model();
      repeat (8) @(posedge clk_i);
      #1;
      rst_n_i = 1'b1;

      start_test();
      assert (available_o == 1'b0) else begin
         $display("Fail reset_state: available_o expected 0 actual %0b", available_o);
         test_errs++;
      end
      assert (checksum_o == '0) else begin
         $display("Fail reset_state: checksum_o expected 0x0 actual 0x%08h", checksum_o);
         test_errs++;
      end
      finish_test("reset_state");

      start_test();
      fill_and_swap(1, 200, 0);
      check_bytes("frame_contents");
      finish_test("frame_contents");

      start_test();
      check_checksum("checksum");   // same frame as above
      finish_test("checksum");

      // samples keep arriving while the host reads the frozen frame
      start_test();
      fill_and_swap(1, 150, 1);
      check_bytes("bank_isolation");
      check_checksum("bank_isolation");
      fill_and_swap(0, 0, 0);       // frame built only from the busy samples
      check_bytes("bank_isolation");
      check_checksum("bank_isolation");
      finish_test("bank_isolation");

      start_test();
      fill_and_swap(2, MAX_SAMPLES, 0);
      check_bytes("repeated_accumulation");
      check_checksum("repeated_accumulation");
      finish_test("repeated_accumulation");

      start_test();
      for (int f = 0; f < 8; f++) begin
         fill_and_swap(1, 200, 0);
         check_bytes("many_frames");
         check_checksum("many_frames");
      end
      finish_test("many_frames");

      $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
               tests_run, tests_run - tests_failed, tests_failed, err_total);
      if (err_total == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

//--- vis_top.f
+incdir+include
rtl/vis_pkg.sv
rtl/correlator_bank.sv
rtl/vis_prefetch.sv
rtl/vis_sram.sv
rtl/vis_readout.sv
rtl/vis_top.sv
verification/vis_tb.sv
